/* verilog/rename_pkg.sv */
package rename_pkg;

    // ----------------------------------------
    // Widths and sizes
    // ----------------------------------------
    parameter int XLEN    = 32;  // Data word
    parameter int REG_NUM = 32;  // Architectural registers
    parameter int REG_W   = 5;   // Register name
    parameter int TAG_W   = 4;   // Rename tag, zero means value ready

    // ----------------------------------------
    // Opcodes and control states
    // ----------------------------------------
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,  // No destination
        OP_BRANCH = 3'd3,  // No destination
        OP_JUMP   = 3'd4   // Link register write
    } op_t;

    typedef enum logic [1:0] {
        ST_RESET = 2'd0,
        ST_RUN   = 2'd1,
        ST_FLUSH = 2'd2
    } ctrl_state_t;

    // True when the instruction writes an architectural register
    function automatic logic writes_rd(op_t op, logic [REG_W-1:0] rd);
        logic no_dest;
        no_dest = (op == OP_STORE) || (op == OP_BRANCH);
        return !no_dest && (rd != '0);
    endfunction

endpackage

/* verilog/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     in_valid,
    input  logic                     rob_full,
    input  logic                     dp_load_ok,
    output logic                     accept,
    output rename_pkg::ctrl_state_t  state
);

    rename_pkg::ctrl_state_t state_next;
    logic                    run_ok;

    // Tags 1..ROB_DEPTH must fit the tag field, zero is reserved
    if (ROB_DEPTH < 2 || ROB_DEPTH >= (1 << rename_pkg::TAG_W)) begin : g_depth_check
        $error("ROB_DEPTH does not fit the rename tag width");
    end

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            rename_pkg::ST_RESET: state_next = rename_pkg::ST_RUN;
            rename_pkg::ST_RUN:   state_next = rename_pkg::ST_RUN;
            rename_pkg::ST_FLUSH: state_next = rename_pkg::ST_RUN;  // One cycle only
            default:              state_next = rename_pkg::ST_RESET;
        endcase
        if (flush) begin
            state_next = rename_pkg::ST_FLUSH;  // Flush wins from any state
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rename_pkg::ST_RESET;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------
    // Accept decision
    // ----------------------------------------
    // A flush pulse also blocks the accept, the instruction would be lost
    // in the same edge that empties the ROB
    assign run_ok = (state == rename_pkg::ST_RUN) && !flush;
    assign accept = in_valid && !rob_full && dp_load_ok && run_ok;

endmodule

/* verilog/reg_rename_file.sv */
`timescale 1ns/1ps

module reg_rename_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,

    // Operand lookup and rename
    input  logic [rename_pkg::REG_W-1:0]  rs1,
    input  logic [rename_pkg::REG_W-1:0]  rs2,
    input  logic [rename_pkg::REG_W-1:0]  rd,
    input  rename_pkg::op_t               op,
    input  logic                          rename_en,
    input  logic [rename_pkg::TAG_W-1:0]  rename_tag,
    output logic [rename_pkg::TAG_W-1:0]  rs1_tag,
    output logic [rename_pkg::TAG_W-1:0]  rs2_tag,
    output logic [rename_pkg::XLEN-1:0]   rs1_value,
    output logic [rename_pkg::XLEN-1:0]   rs2_value,

    // Retirement write-back
    input  logic                          ret_valid,
    input  logic                          ret_has_rd,
    input  logic [rename_pkg::REG_W-1:0]  ret_rd,
    input  logic [rename_pkg::TAG_W-1:0]  ret_tag,
    input  logic [rename_pkg::XLEN-1:0]   ret_value
);

    logic [rename_pkg::XLEN-1:0]  data_q [rename_pkg::REG_NUM];
    logic [rename_pkg::TAG_W-1:0] tag_q  [rename_pkg::REG_NUM];

    logic ret_write;
    logic rs1_hit;
    logic rs2_hit;
    logic do_rename;

    assign ret_write = ret_valid && ret_has_rd && (ret_rd != '0);
    assign do_rename = rename_en && rename_pkg::writes_rd(op, rd);

    // ----------------------------------------
    // Lookup with commit bypass
    // ----------------------------------------
    // Bypass only when the retiring tag still owns the register
    assign rs1_hit = ret_write && (ret_rd == rs1) && (ret_tag == tag_q[rs1]);
    assign rs2_hit = ret_write && (ret_rd == rs2) && (ret_tag == tag_q[rs2]);

    assign rs1_tag   = rs1_hit ? '0 : tag_q[rs1];
    assign rs2_tag   = rs2_hit ? '0 : tag_q[rs2];
    assign rs1_value = rs1_hit ? ret_value : data_q[rs1];
    assign rs2_value = rs2_hit ? ret_value : data_q[rs2];

    // ----------------------------------------
    // Data array
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::REG_NUM; i++) begin
                data_q[i] <= '0;  // x0 reads zero from here on
            end
        end else if (ret_write) begin
            data_q[ret_rd] <= ret_value;  // Kept across flush
        end
    end

    // ----------------------------------------
    // Tag array
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < rename_pkg::REG_NUM; i++) begin
                tag_q[i] <= '0;
            end
        end else begin
            if (ret_write && (tag_q[ret_rd] == ret_tag)) begin
                tag_q[ret_rd] <= '0;  // Owner retired
            end
            if (do_rename) begin
                tag_q[rd] <= rename_tag;  // Younger owner wins
            end
        end
    end

endmodule

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,

    // Allocation
    input  logic                          alloc,
    input  logic [rename_pkg::REG_W-1:0]  alloc_rd,
    input  rename_pkg::op_t               alloc_op,
    output logic [rename_pkg::TAG_W-1:0]  alloc_tag,
    output logic                          full,

    // Completion
    input  logic                          cpl_valid,
    input  logic [rename_pkg::TAG_W-1:0]  cpl_tag,
    input  logic [rename_pkg::XLEN-1:0]   cpl_value,

    // Retirement
    output logic                          ret_valid,
    output logic                          ret_has_rd,
    output logic [rename_pkg::REG_W-1:0]  ret_rd,
    output logic [rename_pkg::TAG_W-1:0]  ret_tag,
    output logic [rename_pkg::XLEN-1:0]   ret_value
);

    localparam int PTR_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    localparam logic [PTR_W-1:0]            PTR_LAST = PTR_W'(ROB_DEPTH - 1);
    localparam logic [PTR_W-1:0]            PTR_ONE  = PTR_W'(1);
    localparam logic [CNT_W-1:0]            CNT_ONE  = CNT_W'(1);
    localparam logic [CNT_W-1:0]            CNT_FULL = CNT_W'(ROB_DEPTH);
    localparam logic [rename_pkg::TAG_W-1:0] TAG_ONE = rename_pkg::TAG_W'(1);

    // Entry storage
    logic [rename_pkg::REG_W-1:0] rd_q     [ROB_DEPTH];
    logic                         has_rd_q [ROB_DEPTH];
    logic [rename_pkg::XLEN-1:0]  value_q  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]         done_q;

    logic [PTR_W-1:0]             head_q;
    logic [PTR_W-1:0]             tail_q;
    logic [CNT_W-1:0]             count_q;
    logic [rename_pkg::TAG_W-1:0] cpl_slot_tag;
    logic [PTR_W-1:0]             cpl_slot;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_LAST) ? '0 : ptr + PTR_ONE;
    endfunction

    function automatic logic [rename_pkg::TAG_W-1:0] slot_tag(logic [PTR_W-1:0] ptr);
        logic [rename_pkg::TAG_W-1:0] t;
        t = '0;
        t[PTR_W-1:0] = ptr;
        return t + TAG_ONE;  // Tag k names slot k-1
    endfunction

    assign alloc_tag    = slot_tag(tail_q);
    assign full         = (count_q == CNT_FULL);
    assign cpl_slot_tag = cpl_tag - TAG_ONE;
    assign cpl_slot     = cpl_slot_tag[PTR_W-1:0];

    // ----------------------------------------
    // Head entry retires once done
    // ----------------------------------------
    assign ret_valid  = (count_q != '0) && done_q[head_q];
    assign ret_has_rd = has_rd_q[head_q];
    assign ret_rd     = rd_q[head_q];
    assign ret_tag    = slot_tag(head_q);
    assign ret_value  = value_q[head_q];

    // Entry payload, written on alloc and completion
    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail_q]     <= alloc_rd;
            has_rd_q[tail_q] <= rename_pkg::writes_rd(alloc_op, alloc_rd);
        end
        if (cpl_valid) begin
            value_q[cpl_slot] <= cpl_value;
        end
    end

    // Pointers, count and done flags
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (cpl_valid) begin
                done_q[cpl_slot] <= 1'b1;  // Any order
            end
            if (alloc) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= ptr_inc(tail_q);
            end
            if (ret_valid) begin
                head_q <= ptr_inc(head_q);
            end
            case ({alloc, ret_valid})
                2'b10:   count_q <= count_q + CNT_ONE;
                2'b01:   count_q <= count_q - CNT_ONE;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* verilog/dispatch_reg.sv */
`timescale 1ns/1ps

module dispatch_reg (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          load,
    output logic                          load_ok,

    input  rename_pkg::op_t               op,
    input  logic [rename_pkg::REG_W-1:0]  rd,
    input  logic [rename_pkg::TAG_W-1:0]  tag,
    input  logic [rename_pkg::TAG_W-1:0]  rs1_tag,
    input  logic [rename_pkg::XLEN-1:0]   rs1_value,
    input  logic [rename_pkg::TAG_W-1:0]  rs2_tag,
    input  logic [rename_pkg::XLEN-1:0]   rs2_value,
    input  logic [rename_pkg::XLEN-1:0]   imm,
    input  logic [rename_pkg::XLEN-1:0]   pc,

    output rename_pkg::op_t               dp_op,
    output logic [rename_pkg::REG_W-1:0]  dp_rd,
    output logic [rename_pkg::TAG_W-1:0]  dp_tag,
    output logic [rename_pkg::TAG_W-1:0]  dp_rs1_tag,
    output logic [rename_pkg::XLEN-1:0]   dp_rs1_value,
    output logic [rename_pkg::TAG_W-1:0]  dp_rs2_tag,
    output logic [rename_pkg::XLEN-1:0]   dp_rs2_value,
    output logic [rename_pkg::XLEN-1:0]   dp_imm,
    output logic [rename_pkg::XLEN-1:0]   dp_pc,
    output logic                          dp_valid,
    input  logic                          dp_ready
);

    assign load_ok = !dp_valid || dp_ready;  // Empty or draining this cycle

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dp_valid <= 1'b0;
        end else if (load) begin
            dp_valid <= 1'b1;
        end else if (dp_ready) begin
            dp_valid <= 1'b0;
        end
    end

    // Payload holds until the next load
    always_ff @(posedge clk) begin
        if (load) begin
            dp_op        <= op;
            dp_rd        <= rd;
            dp_tag       <= tag;
            dp_rs1_tag   <= rs1_tag;
            dp_rs1_value <= rs1_value;
            dp_rs2_tag   <= rs2_tag;
            dp_rs2_value <= rs2_value;
            dp_imm       <= imm;
            dp_pc        <= pc;
        end
    end

endmodule

/* verilog/rename_commit_top.sv */
`timescale 1ns/1ps

module rename_commit_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,

    // Instruction stream
    input  logic                          in_valid,
    input  rename_pkg::op_t               in_op,
    input  logic [rename_pkg::REG_W-1:0]  in_rd,
    input  logic [rename_pkg::REG_W-1:0]  in_rs1,
    input  logic [rename_pkg::REG_W-1:0]  in_rs2,
    input  logic [rename_pkg::XLEN-1:0]   in_imm,
    input  logic [rename_pkg::XLEN-1:0]   in_pc,
    output logic                          in_ready,

    // Dispatch stream
    output logic                          dp_valid,
    output rename_pkg::op_t               dp_op,
    output logic [rename_pkg::REG_W-1:0]  dp_rd,
    output logic [rename_pkg::TAG_W-1:0]  dp_tag,
    output logic [rename_pkg::TAG_W-1:0]  dp_rs1_tag,
    output logic [rename_pkg::XLEN-1:0]   dp_rs1_value,
    output logic [rename_pkg::TAG_W-1:0]  dp_rs2_tag,
    output logic [rename_pkg::XLEN-1:0]   dp_rs2_value,
    output logic [rename_pkg::XLEN-1:0]   dp_imm,
    output logic [rename_pkg::XLEN-1:0]   dp_pc,
    input  logic                          dp_ready,

    // Completion
    input  logic                          cpl_valid,
    input  logic [rename_pkg::TAG_W-1:0]  cpl_tag,
    input  logic [rename_pkg::XLEN-1:0]   cpl_value,

    // Commit
    output logic                          cm_valid,
    output logic [rename_pkg::REG_W-1:0]  cm_rd,
    output logic [rename_pkg::XLEN-1:0]   cm_value
);

    logic                         accept;
    logic                         rob_full;
    logic                         dp_load_ok;
    logic [rename_pkg::TAG_W-1:0] alloc_tag;
    logic [rename_pkg::TAG_W-1:0] rs1_tag;
    logic [rename_pkg::TAG_W-1:0] rs2_tag;
    logic [rename_pkg::XLEN-1:0]  rs1_value;
    logic [rename_pkg::XLEN-1:0]  rs2_value;
    logic                         ret_valid;
    logic                         ret_has_rd;
    logic [rename_pkg::REG_W-1:0] ret_rd;
    logic [rename_pkg::TAG_W-1:0] ret_tag;
    logic [rename_pkg::XLEN-1:0]  ret_value;

    assign in_ready = accept;
    assign cm_valid = ret_valid && ret_has_rd;  // Only register writers pulse
    assign cm_rd    = ret_rd;
    assign cm_value = ret_value;

    issue_ctrl #(.ROB_DEPTH(ROB_DEPTH)) issue_ctrl_i (
        .clk(clk), .rst(rst), .flush(flush), .in_valid(in_valid),
        .rob_full(rob_full), .dp_load_ok(dp_load_ok), .accept(accept),
        .state()
    );

    reg_rename_file reg_rename_file_i (
        .clk(clk), .rst(rst), .flush(flush),
        .rs1(in_rs1), .rs2(in_rs2), .rd(in_rd), .op(in_op),
        .rename_en(accept), .rename_tag(alloc_tag),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .ret_valid(ret_valid), .ret_has_rd(ret_has_rd), .ret_rd(ret_rd),
        .ret_tag(ret_tag), .ret_value(ret_value)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer_i (
        .clk(clk), .rst(rst), .flush(flush),
        .alloc(accept), .alloc_rd(in_rd), .alloc_op(in_op),
        .alloc_tag(alloc_tag), .full(rob_full),
        .cpl_valid(cpl_valid), .cpl_tag(cpl_tag), .cpl_value(cpl_value),
        .ret_valid(ret_valid), .ret_has_rd(ret_has_rd), .ret_rd(ret_rd),
        .ret_tag(ret_tag), .ret_value(ret_value)
    );

    dispatch_reg dispatch_reg_i (
        .clk(clk), .rst(rst), .flush(flush), .load(accept), .load_ok(dp_load_ok),
        .op(in_op), .rd(in_rd), .tag(alloc_tag),
        .rs1_tag(rs1_tag), .rs1_value(rs1_value),
        .rs2_tag(rs2_tag), .rs2_value(rs2_value),
        .imm(in_imm), .pc(in_pc),
        .dp_op(dp_op), .dp_rd(dp_rd), .dp_tag(dp_tag),
        .dp_rs1_tag(dp_rs1_tag), .dp_rs1_value(dp_rs1_value),
        .dp_rs2_tag(dp_rs2_tag), .dp_rs2_value(dp_rs2_value),
        .dp_imm(dp_imm), .dp_pc(dp_pc),
        .dp_valid(dp_valid), .dp_ready(dp_ready)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real HALF_PERIOD = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;  // 8 ns period

endmodule

/* testbench/rename_commit_assertions.sv */
`timescale 1ns/1ps

module rename_commit_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         flush,
    input logic                         in_valid,
    input logic                         in_ready,
    input logic                         dp_valid,
    input logic                         dp_ready,
    input logic [rename_pkg::TAG_W-1:0] dp_tag,
    input logic                         cm_valid
);

    // ----------------------------------------
    // Stream handshakes
    // ----------------------------------------
    in_hold: assert property (@(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=> in_valid)
        else $error("in_valid dropped before in_ready");

    dp_hold: assert property (@(posedge clk) disable iff (rst)
        (dp_valid && !dp_ready && !flush) |=> (dp_valid && $stable(dp_tag)))
        else $error("dispatch packet changed before dp_ready");

    // Count is cleared by the first reset edge
    cm_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !cm_valid)
        else $error("cm_valid high during reset");

    flush_stall: assert property (@(posedge clk) disable iff (rst)
        flush |=> !in_ready)
        else $error("in_ready high in the cycle after flush");

endmodule

bind rename_commit_top rename_commit_assertions rename_commit_assertions_i (
    .clk(clk), .rst(rst), .flush(flush), .in_valid(in_valid), .in_ready(in_ready),
    .dp_valid(dp_valid), .dp_ready(dp_ready), .dp_tag(dp_tag), .cm_valid(cm_valid)
);

/* testbench/rename_commit_tb.sv */
`timescale 1ns/1ps

module rename_commit_tb;

    localparam int ROB_DEPTH = 8;
    localparam int MAX_N     = 128;

    logic clk, rst, flush, in_valid, in_ready, dp_valid, dp_ready;
    logic cpl_valid, cm_valid;
    rename_pkg::op_t in_op, dp_op;
    logic [rename_pkg::REG_W-1:0] in_rd, in_rs1, in_rs2, dp_rd, cm_rd;
    logic [rename_pkg::XLEN-1:0]  in_imm, in_pc, dp_rs1_value, dp_rs2_value;
    logic [rename_pkg::XLEN-1:0]  dp_imm, dp_pc, cpl_value, cm_value;
    logic [rename_pkg::TAG_W-1:0] dp_tag, dp_rs1_tag, dp_rs2_tag, cpl_tag;

    // Golden data indexed by sequence number minus one
    logic [31:0] i_f [MAX_N][11];  // op rd rs1 rs2 imm pc tag r1t r1v r2t r2v
    int          c_seq [MAX_N];
    logic [31:0] c_val [MAX_N];
    logic [31:0] m_rd [MAX_N];
    logic [31:0] m_val [MAX_N];
    byte         cmd_kind [MAX_N];
    int          cmd_arg [MAX_N];
    int          cmd_arg2 [MAX_N];
    int n_instr, n_cpl, n_cm, n_cmd, n_lines;

    int release_lim, send_idx, next_idx, disp_cnt, acc_cnt;
    int cpl_lim, cpl_idx, cm_cnt;
    int cycles, limit, seed, rnd;

    tb_clock clock_gen (.clk(clk));

    rename_commit_top #(.ROB_DEPTH(ROB_DEPTH)) rename_commit_top_i (.*);

    // ----------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------
    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped");
    endtask

    task automatic check_dispatch(input int idx, input rename_pkg::op_t op,
                                  input logic [rename_pkg::REG_W-1:0] rd,
                                  input logic [rename_pkg::TAG_W-1:0] tag, r1t, r2t,
                                  input logic [rename_pkg::XLEN-1:0] r1v, r2v, imm, pc);
        rename_pkg::op_t e_op;
        e_op = rename_pkg::op_t'(i_f[idx][0][2:0]);
        if (op != e_op || rd != i_f[idx][1][4:0] || imm != i_f[idx][4] || pc != i_f[idx][5]
            || tag != i_f[idx][6][3:0] || r1t != i_f[idx][7][3:0] || r1v != i_f[idx][8]
            || r2t != i_f[idx][9][3:0] || r2v != i_f[idx][10]) begin
            report_error($sformatf(
                "dispatch %0d got tag %0d rs1 %0d/%h rs2 %0d/%h, expected %0d %0d/%h %0d/%h",
                idx + 1, tag, r1t, r1v, r2t, r2v, i_f[idx][6], i_f[idx][7], i_f[idx][8],
                i_f[idx][9], i_f[idx][10]));
        end
    endtask

    task automatic check_commit(input int idx, input logic [rename_pkg::REG_W-1:0] rd,
                                input logic [rename_pkg::XLEN-1:0] value);
        if (rd != m_rd[idx][4:0] || value != m_val[idx]) begin
            report_error($sformatf("commit %0d got x%0d=%h, expected x%0d=%h",
                idx + 1, rd, value, m_rd[idx], m_val[idx]));
        end
    endtask

    task automatic load_golden();
        int fd, r;
        string line;
        byte kind;
        fd = $fopen("testbench/rename_golden.txt", "r");
        if (fd == 0) begin
            fail_plain("Could not open testbench/rename_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            kind = (line.len() > 0) ? line.getc(0) : 8'd0;
            if (kind == "I") begin
                r = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h",
                    i_f[n_instr][0], i_f[n_instr][1], i_f[n_instr][2], i_f[n_instr][3],
                    i_f[n_instr][4], i_f[n_instr][5], i_f[n_instr][6], i_f[n_instr][7],
                    i_f[n_instr][8], i_f[n_instr][9], i_f[n_instr][10]);
                n_instr++;
            end else if (kind == "C") begin
                r = $sscanf(line, "C %d %h", c_seq[n_cpl], c_val[n_cpl]);
                n_cpl++;
            end else if (kind == "M") begin
                r = $sscanf(line, "M %h %h", m_rd[n_cm], m_val[n_cm]);
                n_cm++;
            end else if (kind == "D" || kind == "U" || kind == "R" || kind == "F") begin
                cmd_kind[n_cmd] = kind;
                cmd_arg[n_cmd]  = (kind == "R") ? n_cpl : n_instr;
                cmd_arg2[n_cmd] = (kind == "R") ? n_cm : n_instr;
                if (kind == "U") begin
                    r = $sscanf(line, "U %d", cmd_arg[n_cmd]);
                end
                n_cmd++;
            end
            if (kind == "I" || kind == "C" || kind == "M" || kind == "D" || kind == "U"
                || kind == "R" || kind == "F") begin
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------------------
    // Stimulus drivers
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            in_valid <= 1'b0;
        end else begin
            next_idx = send_idx + ((in_valid && in_ready) ? 1 : 0);
            send_idx <= next_idx;
            if (next_idx < release_lim) begin
                in_valid <= 1'b1;
                in_op    <= rename_pkg::op_t'(i_f[next_idx][0][2:0]);
                in_rd    <= i_f[next_idx][1][4:0];
                in_rs1   <= i_f[next_idx][2][4:0];
                in_rs2   <= i_f[next_idx][3][4:0];
                in_imm   <= i_f[next_idx][4];
                in_pc    <= i_f[next_idx][5];
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        dp_ready <= rst ? 1'b0 : rnd[0];
    end

    // A completion waits until its instruction has been dispatched
    always @(posedge clk) begin
        if (!rst && cpl_idx < cpl_lim && disp_cnt >= c_seq[cpl_idx]) begin
            cpl_valid <= 1'b1;
            cpl_tag   <= i_f[c_seq[cpl_idx] - 1][6][3:0];
            cpl_value <= c_val[cpl_idx];
            cpl_idx   <= cpl_idx + 1;
        end else begin
            cpl_valid <= 1'b0;
        end
    end

    // ----------------------------------------
    // Monitors
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst && in_valid && in_ready) begin
            acc_cnt <= acc_cnt + 1;
        end
        if (!rst && dp_valid && dp_ready) begin
            disp_cnt <= disp_cnt + 1;
            if (disp_cnt >= release_lim) begin
                fail_plain("A dispatch packet came out that was never sent");
            end else begin
                check_dispatch(disp_cnt, dp_op, dp_rd, dp_tag, dp_rs1_tag, dp_rs2_tag,
                               dp_rs1_value, dp_rs2_value, dp_imm, dp_pc);
            end
        end
        if (!rst && cm_valid) begin
            cm_cnt <= cm_cnt + 1;
            if (cm_cnt >= n_cm) begin
                fail_plain("A commit pulse came out that was not expected");
            end else begin
                check_commit(cm_cnt, cm_rd, cm_value);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // Command sequence
    // ----------------------------------------
    initial begin
        seed = 2345;
        rst = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        in_op = rename_pkg::OP_ALU;
        in_rd = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_imm = '0;
        in_pc = '0;
        dp_ready = 1'b0;
        cpl_valid = 1'b0;
        cpl_tag = '0;
        cpl_value = '0;
        {n_instr, n_cpl, n_cm, n_cmd, n_lines} = '0;
        {release_lim, send_idx, disp_cnt, acc_cnt, cpl_lim, cpl_idx, cm_cnt} = '0;
        cycles = 0;
        limit = 0;
        load_golden();
        limit = 40 * n_lines;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int k = 0; k < n_cmd; k++) begin
            if (cmd_kind[k] == "D" || cmd_kind[k] == "U") begin
                release_lim <= cmd_arg2[k];
                while (disp_cnt < cmd_arg[k]) @(posedge clk);
                if (cmd_kind[k] == "U") begin
                    repeat (6) @(posedge clk);  // Next instruction offered meanwhile
                    if (acc_cnt != cmd_arg[k]) begin
                        fail_plain("An instruction was accepted while the ROB was full");
                    end
                end
            end else if (cmd_kind[k] == "R") begin
                cpl_lim <= cmd_arg[k];
                while (cpl_idx < cmd_arg[k] || cm_cnt < cmd_arg2[k]) @(posedge clk);
                repeat (ROB_DEPTH + 2) @(posedge clk);  // Silent retirements drain
            end else begin
                // Instructions after the flush are offered while it is applied
                if (k + 1 < n_cmd && (cmd_kind[k + 1] == "D" || cmd_kind[k + 1] == "U")) begin
                    release_lim <= cmd_arg2[k + 1];
                end
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
                @(posedge clk);
            end
        end
        if (disp_cnt == n_instr && cm_cnt == n_cm) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_plain($sformatf("Run ended with %0d of %0d dispatches and %0d of %0d commits",
                disp_cnt, n_instr, cm_cnt, n_cm));
        end
    end

endmodule

/* testbench/rename_golden.txt */
# I op rd rs1 rs2 imm pc tag rs1_tag rs1_val rs2_tag rs2_val (hex); D wait dispatch; U n full hold
# C seq val: completion; M rd val: expected commit; R run completions; F flush
I 0 1 0 0 10 100 1 0 0 0 0
I 0 2 1 0 20 104 2 1 0 0 0
I 0 1 2 1 30 108 3 2 0 1 0
I 1 3 1 2 40 10c 4 3 0 2 0
D
C 3 33
C 1 11
C 4 44
C 2 22
M 1 11
M 2 22
M 1 33
M 3 44
R
I 0 4 1 2 50 110 5 0 33 0 22
I 0 4 3 0 60 114 6 0 44 0 0
D
C 5 55
M 4 55
R
I 2 4 4 1 70 118 7 6 55 0 33
I 3 4 4 0 80 11c 8 6 55 0 0
I 0 0 4 3 90 120 1 6 55 0 44
I 0 5 0 4 a0 124 2 0 0 6 55
D
C 9 99
C 7 77
C 6 66
C 10 5a
C 8 88
M 4 66
M 5 5a
R
I 0 6 1 4 b0 128 3 0 33 0 66
I 0 7 6 5 c0 12c 4 3 0 0 5a
I 0 8 0 0 0 130 5 0 0 0 0
I 0 9 0 0 0 134 6 0 0 0 0
I 0 a 0 0 0 138 7 0 0 0 0
I 0 b 0 0 0 13c 8 0 0 0 0
I 0 c 0 0 0 140 1 0 0 0 0
I 0 d 0 0 0 144 2 0 0 0 0
I 0 0 0 0 0 148 3 0 0 0 0
U 18
C 11 61
C 13 80
C 12 72
C 14 81
C 15 82
C 16 83
C 17 84
C 18 85
C 19 0
M 6 61
M 7 72
M 8 80
M 9 81
M a 82
M b 83
M c 84
M d 85
R
I 0 1 1 0 0 14c 4 0 33 0 0
I 0 2 1 2 0 150 5 4 33 0 22
D
F
I 0 3 1 2 0 154 1 0 33 0 22
I 1 4 3 7 0 158 2 1 44 0 72
D
C 23 aa
C 22 bb
M 3 bb
M 4 aa
R

/* sim.f */
verilog/rename_pkg.sv
verilog/issue_ctrl.sv
verilog/reg_rename_file.sv
verilog/reorder_buffer.sv
verilog/dispatch_reg.sv
verilog/rename_commit_top.sv
testbench/tb_clock.sv
testbench/rename_commit_assertions.sv
testbench/rename_commit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rename and commit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_commit_tb -f sim.f -o rename_sim

out=$(./obj_dir/rename_sim) || true
echo "$out"

echo "$out" | grep -q "ALL CHECKS PASSED"
